// File: include/tlx_cmd_defs.svh
// widths, queue depth, credit reserves and dl codes for the TLX command converter
// included by the package and by every RTL file that needs a constant
`ifndef TLX_CMD_DEFS_SVH
`define TLX_CMD_DEFS_SVH

// ------------------------------
// queues
// ------------------------------

// 5 address bits give a depth of 32 entries
`define FIFO_ADDR_WIDTH 5

// pasid + actag + pl + dl + afutag + ea + opcode = 20+12+3+2+16+68+8
`define CMD_WORD_WIDTH 129

// one 128 byte write entry, sent as two beats
`define WDATA_WIDTH 1024
`define BEAT_WIDTH 512

// ------------------------------
// credits
// ------------------------------

// credits kept back to cover takes still in flight behind the registered flags
`define CMD_CREDIT_RESERVE 3
`define DATA_CREDIT_RESERVE 4

// dl codes
`define DL_64B 2'd1
`define DL_128B 2'd2

`endif

// File: logic/tlx_cmd_pkg.sv
// field and word types shared by the queues, the arbiter and the issue stage
// import with a wildcard in module bodies, use scoped names in port lists
`default_nettype none

`include "tlx_cmd_defs.svh"

package tlx_cmd_pkg;

   // command fields as they appear on the TLX command interface
   typedef logic [7:0] opcode_t;
   typedef logic [67:0] ea_t;
   typedef logic [15:0] afutag_t;
   typedef logic [1:0] dl_t;
   typedef logic [2:0] pl_t;
   typedef logic [11:0] actag_t;
   typedef logic [19:0] pasid_t;

   // packed command word, pasid in the top bits and opcode in the bottom bits
   typedef logic [`CMD_WORD_WIDTH-1:0] cmd_word_t;

   // write data, one entry per 128 byte write
   typedef logic [`WDATA_WIDTH-1:0] wdata_t;

   // one 64 byte beat on afu_tlx_cdata_bus
   typedef logic [`BEAT_WIDTH-1:0] beat_t;

endpackage

`default_nettype wire

// File: logic/cmd_fifo.sv
// synchronous show-ahead queue with fill count, half-full indication and sticky overflow
// the head is valid whenever not_empty is high, pop drops it at the clock edge
`default_nettype none

module cmd_fifo #(
   parameter int WIDTH = 129,
   parameter int ADDR_WIDTH = 5
) (
   input wire clk_tlx,
   input wire rst_n,
   input wire push,
   input wire [WIDTH-1:0] push_data,
   input wire pop,
   output logic [WIDTH-1:0] head,
   output logic not_empty,
   output logic below_half,
   output logic overflow
);

   localparam int DEPTH = 1 << ADDR_WIDTH;
   localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH + 1)'(DEPTH);
   localparam logic [ADDR_WIDTH:0] HALF_COUNT = (ADDR_WIDTH + 1)'(DEPTH / 2);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [ADDR_WIDTH-1:0] wr_ptr;
   logic [ADDR_WIDTH-1:0] rd_ptr;
   logic [ADDR_WIDTH:0] count;
   logic full;
   logic do_push;
   logic do_pop;

   assign full = (count == FULL_COUNT);
   // a push into a full queue is dropped, even with a pop in the same cycle
   assign do_push = push && !full;
   assign do_pop = pop && not_empty;

   assign head = mem[rd_ptr];
   assign not_empty = (count != '0);
   assign below_half = (count < HALF_COUNT);

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge clk_tlx)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= push_data;
      end
   end

   // ------------------------------
   // pointers and fill count
   // ------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: ;
         endcase
      end
   end

   // sticky until reset
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         overflow <= 1'b0;
      end
      else if (push && full)
      begin
         overflow <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: logic/cmd_arbiter.sv
// alternates between the write and read command queues into a single held slot
// the slot refills in the cycle it is taken, popping the chosen queue at the same edge
`default_nettype none

module cmd_arbiter (
   input wire clk_tlx,
   input wire rst_n,
   input wire tlx_cmd_pkg::cmd_word_t wr_head,
   input wire wr_not_empty,
   input wire tlx_cmd_pkg::cmd_word_t rd_head,
   input wire rd_not_empty,
   input wire slot_take,
   output logic wr_pop,
   output logic rd_pop,
   output logic slot_valid,
   output tlx_cmd_pkg::cmd_word_t slot_word,
   output logic slot_is_write
);

   import tlx_cmd_pkg::*;

   // high while the write queue has the next turn
   logic turn_write;
   logic slot_free;
   logic load;
   logic pick_write;
   cmd_word_t load_word;

   // ------------------------------
   // selection
   // ------------------------------

   // preferred queue first, the other one when the preferred queue is empty
   assign pick_write = wr_not_empty && (turn_write || !rd_not_empty);

   assign slot_free = !slot_valid || slot_take;
   assign load = slot_free && (wr_not_empty || rd_not_empty);

   assign wr_pop = load && pick_write;
   assign rd_pop = load && !pick_write;

   assign load_word = pick_write ? wr_head : rd_head;

   // ------------------------------
   // turn and slot state
   // ------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         turn_write <= 1'b1;
         slot_valid <= 1'b0;
      end
      else if (load)
      begin
         // hand the next turn to the queue that was not served
         turn_write <= !pick_write;
         slot_valid <= 1'b1;
      end
      else if (slot_take)
      begin
         slot_valid <= 1'b0;
      end
   end

   // slot payload, qualified by slot_valid
   always_ff @(posedge clk_tlx)
   begin
      if (load)
      begin
         slot_word <= load_word;
         slot_is_write <= pick_write;
      end
   end

endmodule

`default_nettype wire

// File: logic/cmd_issue.sv
// drives commands onto the TLX under credit gating and follows each write with its data beats
// one beat for a 64 byte write, low half then high half for a 128 byte write
`default_nettype none

`include "tlx_cmd_defs.svh"

module cmd_issue (
   input wire clk_tlx,
   input wire rst_n,
   input wire slot_valid,
   input wire tlx_cmd_pkg::cmd_word_t slot_word,
   input wire slot_is_write,
   input wire cmd_credit_ok,
   input wire data_credit_ok,
   input wire tlx_cmd_pkg::wdata_t wdata_head,
   output logic slot_take,
   output logic wdata_pop,
   output logic afu_tlx_cmd_valid,
   output tlx_cmd_pkg::opcode_t afu_tlx_cmd_opcode,
   output tlx_cmd_pkg::ea_t afu_tlx_cmd_ea_or_obj,
   output tlx_cmd_pkg::afutag_t afu_tlx_cmd_afutag,
   output tlx_cmd_pkg::dl_t afu_tlx_cmd_dl,
   output tlx_cmd_pkg::pl_t afu_tlx_cmd_pl,
   output tlx_cmd_pkg::actag_t afu_tlx_cmd_actag,
   output tlx_cmd_pkg::pasid_t afu_tlx_cmd_pasid,
   output logic afu_tlx_cdata_valid,
   output tlx_cmd_pkg::beat_t afu_tlx_cdata_bus
);

   import tlx_cmd_pkg::*;

   opcode_t slot_opcode;
   ea_t slot_ea;
   afutag_t slot_afutag;
   dl_t slot_dl;
   pl_t slot_pl;
   actag_t slot_actag;
   pasid_t slot_pasid;

   logic cmd_is_write;
   logic beat_high;
   logic beat_last;
   logic data_busy;

   // unpack the slot word, same field order as the AFU side
   assign {slot_pasid, slot_actag, slot_pl, slot_dl, slot_afutag, slot_ea, slot_opcode} =
      slot_word;

   // ------------------------------
   // take gating
   // ------------------------------

   // beats still owed beyond the one on the bus this cycle
   assign data_busy = (afu_tlx_cmd_valid && cmd_is_write) ||
                      (afu_tlx_cdata_valid && !beat_last);

   assign slot_take = slot_valid && cmd_credit_ok && data_credit_ok && !data_busy;

   // command valid is a one cycle pulse after each take
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         afu_tlx_cmd_valid <= 1'b0;
         cmd_is_write <= 1'b0;
      end
      else
      begin
         afu_tlx_cmd_valid <= slot_take;
         if (slot_take)
         begin
            cmd_is_write <= slot_is_write;
         end
      end
   end

   always_ff @(posedge clk_tlx)
   begin
      if (slot_take)
      begin
         afu_tlx_cmd_opcode <= slot_opcode;
         afu_tlx_cmd_ea_or_obj <= slot_ea;
         afu_tlx_cmd_afutag <= slot_afutag;
         afu_tlx_cmd_dl <= slot_dl;
         afu_tlx_cmd_pl <= slot_pl;
         afu_tlx_cmd_actag <= slot_actag;
         afu_tlx_cmd_pasid <= slot_pasid;
      end
   end

   // ------------------------------
   // data beats
   // ------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         afu_tlx_cdata_valid <= 1'b0;
         beat_high <= 1'b0;
         beat_last <= 1'b0;
      end
      else if (afu_tlx_cmd_valid && cmd_is_write)
      begin
         // low half right after the write command
         afu_tlx_cdata_valid <= 1'b1;
         beat_high <= 1'b0;
         beat_last <= (afu_tlx_cmd_dl != `DL_128B);
      end
      else if (afu_tlx_cdata_valid && !beat_last)
      begin
         afu_tlx_cdata_valid <= 1'b1;
         beat_high <= 1'b1;
         beat_last <= 1'b1;
      end
      else
      begin
         afu_tlx_cdata_valid <= 1'b0;
      end
   end

   // the data head stays put until its last beat has gone out
   assign afu_tlx_cdata_bus = beat_high ? wdata_head[`WDATA_WIDTH-1:`BEAT_WIDTH] :
                                          wdata_head[`BEAT_WIDTH-1:0];

   assign wdata_pop = afu_tlx_cdata_valid && beat_last;

endmodule

`default_nettype wire

// File: logic/credit_tracker.sv
// command and data credit counters with registered credit-ok flags and sticky breach bits
// counters load the TLX initial credits in the first cycle after reset
`default_nettype none

`include "tlx_cmd_defs.svh"

module credit_tracker (
   input wire clk_tlx,
   input wire rst_n,
   input wire tlx_afu_cmd_credit,
   input wire tlx_afu_cmd_data_credit,
   input wire [3:0] tlx_afu_cmd_initial_credit,
   input wire [5:0] tlx_afu_cmd_data_initial_credit,
   input wire cmd_sent,
   input wire beat_sent,
   output logic cmd_credit_ok,
   output logic data_credit_ok,
   output logic [1:0] credit_breach
);

   localparam logic [3:0] CMD_RESERVE = 4'(`CMD_CREDIT_RESERVE);
   localparam logic [5:0] DATA_RESERVE = 6'(`DATA_CREDIT_RESERVE);

   logic load_pending;
   logic [3:0] cmd_cnt;
   logic [5:0] data_cnt;

   // ------------------------------
   // counters
   // ------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         load_pending <= 1'b1;
         cmd_cnt <= '0;
         data_cnt <= '0;
      end
      else if (load_pending)
      begin
         load_pending <= 1'b0;
         cmd_cnt <= tlx_afu_cmd_initial_credit;
         data_cnt <= tlx_afu_cmd_data_initial_credit;
      end
      else
      begin
         case ({tlx_afu_cmd_credit, cmd_sent})
            2'b10: cmd_cnt <= cmd_cnt + 4'd1;
            2'b01: cmd_cnt <= cmd_cnt - 4'd1;
            default: ;
         endcase
         case ({tlx_afu_cmd_data_credit, beat_sent})
            2'b10: data_cnt <= data_cnt + 6'd1;
            2'b01: data_cnt <= data_cnt - 6'd1;
            default: ;
         endcase
      end
   end

   // flags lag the counts by a cycle, the reserves absorb that
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_credit_ok <= 1'b0;
         data_credit_ok <= 1'b0;
      end
      else
      begin
         cmd_credit_ok <= (cmd_cnt > CMD_RESERVE);
         data_credit_ok <= (data_cnt > DATA_RESERVE);
      end
   end

   // ------------------------------
   // breach detection
   // ------------------------------

   // bit 1 command, bit 0 data
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         credit_breach <= 2'b00;
      end
      else
      begin
         if (cmd_sent && (cmd_cnt == 4'd0))
         begin
            credit_breach[1] <= 1'b1;
         end
         if (beat_sent && (data_cnt == 6'd0))
         begin
            credit_breach[0] <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/tlx_cmd_converter.sv
// top of the TLX command converter: AFU write and read queues, arbiter, issue and credits
// fir_fifo_overflow is {write command, read command, write data}
`default_nettype none

`include "tlx_cmd_defs.svh"

module tlx_cmd_converter (
   input wire clk_tlx,
   input wire rst_n,
   // AFU write channel
   input wire tlx_wr_cmd_valid,
   input wire tlx_cmd_pkg::opcode_t tlx_wr_cmd_opcode,
   input wire tlx_cmd_pkg::ea_t tlx_wr_cmd_ea_or_obj,
   input wire tlx_cmd_pkg::afutag_t tlx_wr_cmd_afutag,
   input wire tlx_cmd_pkg::dl_t tlx_wr_cmd_dl,
   input wire tlx_cmd_pkg::pl_t tlx_wr_cmd_pl,
   input wire tlx_cmd_pkg::actag_t tlx_wr_cmd_actag,
   input wire tlx_cmd_pkg::pasid_t tlx_wr_cmd_pasid,
   input wire tlx_cmd_pkg::wdata_t tlx_wr_cdata_bus,
   output logic tlx_wr_cmd_ready,
   // AFU read channel
   input wire tlx_rd_cmd_valid,
   input wire tlx_cmd_pkg::opcode_t tlx_rd_cmd_opcode,
   input wire tlx_cmd_pkg::ea_t tlx_rd_cmd_ea_or_obj,
   input wire tlx_cmd_pkg::afutag_t tlx_rd_cmd_afutag,
   input wire tlx_cmd_pkg::dl_t tlx_rd_cmd_dl,
   input wire tlx_cmd_pkg::pl_t tlx_rd_cmd_pl,
   input wire tlx_cmd_pkg::actag_t tlx_rd_cmd_actag,
   input wire tlx_cmd_pkg::pasid_t tlx_rd_cmd_pasid,
   output logic tlx_rd_cmd_ready,
   // TLX credits
   input wire tlx_afu_cmd_credit,
   input wire tlx_afu_cmd_data_credit,
   input wire [3:0] tlx_afu_cmd_initial_credit,
   input wire [5:0] tlx_afu_cmd_data_initial_credit,
   // TLX command and data
   output logic afu_tlx_cmd_valid,
   output tlx_cmd_pkg::opcode_t afu_tlx_cmd_opcode,
   output tlx_cmd_pkg::ea_t afu_tlx_cmd_ea_or_obj,
   output tlx_cmd_pkg::afutag_t afu_tlx_cmd_afutag,
   output tlx_cmd_pkg::dl_t afu_tlx_cmd_dl,
   output tlx_cmd_pkg::pl_t afu_tlx_cmd_pl,
   output tlx_cmd_pkg::actag_t afu_tlx_cmd_actag,
   output tlx_cmd_pkg::pasid_t afu_tlx_cmd_pasid,
   output logic afu_tlx_cdata_valid,
   output tlx_cmd_pkg::beat_t afu_tlx_cdata_bus,
   // faults
   output logic [2:0] fir_fifo_overflow,
   output logic [1:0] fir_tlx_command_credit
);

   import tlx_cmd_pkg::*;

   cmd_word_t wr_head;
   cmd_word_t rd_head;
   cmd_word_t slot_word;
   wdata_t wdata_head;
   logic wr_not_empty;
   logic rd_not_empty;
   logic wr_pop;
   logic rd_pop;
   logic wdata_pop;
   logic slot_valid;
   logic slot_is_write;
   logic slot_take;
   logic cmd_credit_ok;
   logic data_credit_ok;

   // ------------------------------
   // AFU side queues
   // ------------------------------
   cmd_fifo #(.WIDTH(`CMD_WORD_WIDTH), .ADDR_WIDTH(`FIFO_ADDR_WIDTH)) u_wr_cmd_fifo (
      .clk_tlx(clk_tlx), .rst_n(rst_n), .push(tlx_wr_cmd_valid),
      .push_data({tlx_wr_cmd_pasid, tlx_wr_cmd_actag, tlx_wr_cmd_pl, tlx_wr_cmd_dl,
                  tlx_wr_cmd_afutag, tlx_wr_cmd_ea_or_obj, tlx_wr_cmd_opcode}),
      .pop(wr_pop), .head(wr_head), .not_empty(wr_not_empty),
      .below_half(tlx_wr_cmd_ready), .overflow(fir_fifo_overflow[2]));

   cmd_fifo #(.WIDTH(`CMD_WORD_WIDTH), .ADDR_WIDTH(`FIFO_ADDR_WIDTH)) u_rd_cmd_fifo (
      .clk_tlx(clk_tlx), .rst_n(rst_n), .push(tlx_rd_cmd_valid),
      .push_data({tlx_rd_cmd_pasid, tlx_rd_cmd_actag, tlx_rd_cmd_pl, tlx_rd_cmd_dl,
                  tlx_rd_cmd_afutag, tlx_rd_cmd_ea_or_obj, tlx_rd_cmd_opcode}),
      .pop(rd_pop), .head(rd_head), .not_empty(rd_not_empty),
      .below_half(tlx_rd_cmd_ready), .overflow(fir_fifo_overflow[1]));

   // filled together with the write command queue, so its head matches the issuing write
   cmd_fifo #(.WIDTH(`WDATA_WIDTH), .ADDR_WIDTH(`FIFO_ADDR_WIDTH)) u_wr_data_fifo (
      .clk_tlx(clk_tlx), .rst_n(rst_n), .push(tlx_wr_cmd_valid),
      .push_data(tlx_wr_cdata_bus), .pop(wdata_pop), .head(wdata_head),
      .not_empty(), .below_half(), .overflow(fir_fifo_overflow[0]));

   // ------------------------------
   // arbitration, issue and credits
   // ------------------------------
   cmd_arbiter u_arbiter (
      .clk_tlx(clk_tlx), .rst_n(rst_n),
      .wr_head(wr_head), .wr_not_empty(wr_not_empty),
      .rd_head(rd_head), .rd_not_empty(rd_not_empty),
      .slot_take(slot_take), .wr_pop(wr_pop), .rd_pop(rd_pop),
      .slot_valid(slot_valid), .slot_word(slot_word), .slot_is_write(slot_is_write));

   cmd_issue u_issue (
      .clk_tlx(clk_tlx), .rst_n(rst_n),
      .slot_valid(slot_valid), .slot_word(slot_word), .slot_is_write(slot_is_write),
      .cmd_credit_ok(cmd_credit_ok), .data_credit_ok(data_credit_ok),
      .wdata_head(wdata_head), .slot_take(slot_take), .wdata_pop(wdata_pop),
      .afu_tlx_cmd_valid(afu_tlx_cmd_valid), .afu_tlx_cmd_opcode(afu_tlx_cmd_opcode),
      .afu_tlx_cmd_ea_or_obj(afu_tlx_cmd_ea_or_obj), .afu_tlx_cmd_afutag(afu_tlx_cmd_afutag),
      .afu_tlx_cmd_dl(afu_tlx_cmd_dl), .afu_tlx_cmd_pl(afu_tlx_cmd_pl),
      .afu_tlx_cmd_actag(afu_tlx_cmd_actag), .afu_tlx_cmd_pasid(afu_tlx_cmd_pasid),
      .afu_tlx_cdata_valid(afu_tlx_cdata_valid), .afu_tlx_cdata_bus(afu_tlx_cdata_bus));

   credit_tracker u_credit_tracker (
      .clk_tlx(clk_tlx), .rst_n(rst_n),
      .tlx_afu_cmd_credit(tlx_afu_cmd_credit),
      .tlx_afu_cmd_data_credit(tlx_afu_cmd_data_credit),
      .tlx_afu_cmd_initial_credit(tlx_afu_cmd_initial_credit),
      .tlx_afu_cmd_data_initial_credit(tlx_afu_cmd_data_initial_credit),
      .cmd_sent(afu_tlx_cmd_valid), .beat_sent(afu_tlx_cdata_valid),
      .cmd_credit_ok(cmd_credit_ok), .data_credit_ok(data_credit_ok),
      .credit_breach(fir_tlx_command_credit));

endmodule

`default_nettype wire

// File: tests/tb_tlx_cmd_converter.sv
// testbench for the TLX command converter with AFU stimulus, a TLX credit model and scoreboards
// compile from the file list with tb_tlx_cmd_converter as top
`default_nettype none

`include "tlx_cmd_defs.svh"

module tb_tlx_cmd_converter;

   import tlx_cmd_pkg::*;

   // five tests of well under 2000 cycles in total, limit about ten times that
   localparam int MAX_CYCLES = 20000;
   localparam int DRAIN_LIMIT = 2000;
   // cycles between a command or beat and its returned credit
   localparam int RET_DELAY = 4;

   logic clk_tlx;
   logic rst_n;
   logic tlx_wr_cmd_valid;
   opcode_t tlx_wr_cmd_opcode;
   ea_t tlx_wr_cmd_ea_or_obj;
   afutag_t tlx_wr_cmd_afutag;
   dl_t tlx_wr_cmd_dl;
   pl_t tlx_wr_cmd_pl;
   actag_t tlx_wr_cmd_actag;
   pasid_t tlx_wr_cmd_pasid;
   wdata_t tlx_wr_cdata_bus;
   logic tlx_wr_cmd_ready;
   logic tlx_rd_cmd_valid;
   opcode_t tlx_rd_cmd_opcode;
   ea_t tlx_rd_cmd_ea_or_obj;
   afutag_t tlx_rd_cmd_afutag;
   dl_t tlx_rd_cmd_dl;
   pl_t tlx_rd_cmd_pl;
   actag_t tlx_rd_cmd_actag;
   pasid_t tlx_rd_cmd_pasid;
   logic tlx_rd_cmd_ready;
   logic tlx_afu_cmd_credit;
   logic tlx_afu_cmd_data_credit;
   logic [3:0] tlx_afu_cmd_initial_credit;
   logic [5:0] tlx_afu_cmd_data_initial_credit;
   logic afu_tlx_cmd_valid;
   opcode_t afu_tlx_cmd_opcode;
   ea_t afu_tlx_cmd_ea_or_obj;
   afutag_t afu_tlx_cmd_afutag;
   dl_t afu_tlx_cmd_dl;
   pl_t afu_tlx_cmd_pl;
   actag_t afu_tlx_cmd_actag;
   pasid_t afu_tlx_cmd_pasid;
   logic afu_tlx_cdata_valid;
   beat_t afu_tlx_cdata_bus;
   logic [2:0] fir_fifo_overflow;
   logic [1:0] fir_tlx_command_credit;

   // scoreboards, one per source, in issue order
   cmd_word_t exp_wr_cmds[$];
   cmd_word_t exp_rd_cmds[$];
   wdata_t exp_wr_data[$];
   dl_t exp_wr_dl[$];
   beat_t exp_beats[$];
   // 1 for a write, per issued command
   logic issued_log[$];

   // TLX side credit view
   int cmd_avail;
   int data_avail;
   int cmd_grant_req;
   int cmd_grant_done;
   int data_grant_req;
   int data_grant_done;
   logic [RET_DELAY-1:0] cmd_ret_pipe;
   logic [RET_DELAY-1:0] data_ret_pipe;

   string cur_test;
   int errors = 0;
   int test_err_start;
   int tests_run = 0;
   int tests_failed = 0;
   int cycles = 0;

   tlx_cmd_converter dut (.*);

   initial
   begin
      clk_tlx = 1'b0;
      forever #5 clk_tlx = ~clk_tlx;
   end

   always @(posedge clk_tlx)
   begin
      cycles++;
   end

   initial
   begin
      wait (cycles >= MAX_CYCLES);
      $display("timeout: run stopped after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
   end

   function automatic cmd_word_t pack_word(input opcode_t op, input ea_t ea, input afutag_t tag,
                                           input dl_t dl, input pl_t pl, input actag_t act,
                                           input pasid_t pasid);
      return {pasid, act, pl, dl, tag, ea, op};
   endfunction

   // ------------------------------
   // TLX model and checks
   // ------------------------------
   task automatic check_command(input cmd_word_t got, input logic is_write);
      cmd_word_t exp;
      wdata_t data;
      dl_t dl;
      if (is_write ? (exp_wr_cmds.size() == 0) : (exp_rd_cmds.size() == 0))
      begin
         $display("%s: a command was issued with none pending from its queue", cur_test);
         errors++;
      end
      else
      begin
         exp = is_write ? exp_wr_cmds.pop_front() : exp_rd_cmds.pop_front();
         assert (got == exp)
         else
         begin
            $display("mismatch in %s: command expected %h, actual %h", cur_test, exp, got);
            errors++;
         end
         if (is_write)
         begin
            data = exp_wr_data.pop_front();
            dl = exp_wr_dl.pop_front();
            exp_beats.push_back(data[`BEAT_WIDTH-1:0]);
            if (dl == `DL_128B)
            begin
               exp_beats.push_back(data[`WDATA_WIDTH-1:`BEAT_WIDTH]);
            end
         end
      end
   endtask

   always @(negedge clk_tlx)
   begin : tlx_model
      beat_t exp_beat;
      logic cmd_due;
      logic data_due;
      if (rst_n !== 1'b1)
      begin
         cmd_ret_pipe = '0;
         data_ret_pipe = '0;
         tlx_afu_cmd_credit = 1'b0;
         tlx_afu_cmd_data_credit = 1'b0;
      end
      else
      begin
         // beats come back to back right after their write command
         assert (afu_tlx_cdata_valid == (exp_beats.size() != 0))
         else
         begin
            $display("mismatch in %s: cdata_valid expected %0b, actual %0b", cur_test,
                     exp_beats.size() != 0, afu_tlx_cdata_valid);
            errors++;
         end
         if (afu_tlx_cdata_valid)
         begin
            assert (data_avail > 0)
            else
            begin
               $display("%s: data beat sent with no data credit left", cur_test);
               errors++;
            end
            data_avail--;
            if (exp_beats.size() != 0)
            begin
               exp_beat = exp_beats.pop_front();
               assert (afu_tlx_cdata_bus == exp_beat)
               else
               begin
                  $display("mismatch in %s: beat expected %h, actual %h", cur_test,
                           exp_beat, afu_tlx_cdata_bus);
                  errors++;
               end
            end
         end
         if (afu_tlx_cmd_valid)
         begin
            assert (cmd_avail > 0)
            else
            begin
               $display("%s: command sent with no command credit left", cur_test);
               errors++;
            end
            cmd_avail--;
            issued_log.push_back(afu_tlx_cmd_afutag[15]);
            check_command(pack_word(afu_tlx_cmd_opcode, afu_tlx_cmd_ea_or_obj,
                                    afu_tlx_cmd_afutag, afu_tlx_cmd_dl, afu_tlx_cmd_pl,
                                    afu_tlx_cmd_actag, afu_tlx_cmd_pasid),
                          afu_tlx_cmd_afutag[15]);
         end
         assert (fir_tlx_command_credit == 2'b00)
         else
         begin
            $display("mismatch in %s: credit fault expected 00, actual %b", cur_test,
                     fir_tlx_command_credit);
            errors++;
         end
         // returns first, extra grants fill the free cycles
         cmd_due = cmd_ret_pipe[RET_DELAY-1];
         data_due = data_ret_pipe[RET_DELAY-1];
         cmd_ret_pipe = {cmd_ret_pipe[RET_DELAY-2:0], afu_tlx_cmd_valid};
         data_ret_pipe = {data_ret_pipe[RET_DELAY-2:0], afu_tlx_cdata_valid};
         tlx_afu_cmd_credit = cmd_due || (cmd_grant_done < cmd_grant_req);
         tlx_afu_cmd_data_credit = data_due || (data_grant_done < data_grant_req);
         if (!cmd_due && tlx_afu_cmd_credit)
         begin
            cmd_grant_done++;
         end
         if (!data_due && tlx_afu_cmd_data_credit)
         begin
            data_grant_done++;
         end
         if (tlx_afu_cmd_credit)
         begin
            cmd_avail++;
         end
         if (tlx_afu_cmd_data_credit)
         begin
            data_avail++;
         end
      end
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   task automatic apply_reset(input int cmd_init, input int data_init);
      @(negedge clk_tlx);
      rst_n = 1'b0;
      tlx_wr_cmd_valid = 1'b0;
      tlx_rd_cmd_valid = 1'b0;
      tlx_afu_cmd_initial_credit = 4'(cmd_init);
      tlx_afu_cmd_data_initial_credit = 6'(data_init);
      repeat (16) @(negedge clk_tlx);
      assert ({afu_tlx_cmd_valid, afu_tlx_cdata_valid, fir_fifo_overflow} == 5'b0)
      else
      begin
         $display("%s: outputs not low while in reset", cur_test);
         errors++;
      end
      exp_wr_cmds.delete();
      exp_rd_cmds.delete();
      exp_wr_data.delete();
      exp_wr_dl.delete();
      exp_beats.delete();
      issued_log.delete();
      cmd_avail = cmd_init;
      data_avail = data_init;
      cmd_grant_req = 0;
      cmd_grant_done = 0;
      data_grant_req = 0;
      data_grant_done = 0;
      rst_n = 1'b1;
      repeat (4) @(negedge clk_tlx);
   endtask

   task automatic return_credits(input int n_cmd, input int n_data);
      cmd_grant_req += n_cmd;
      data_grant_req += n_data;
   endtask

   task automatic send_cmds(input logic do_wr, input logic do_rd, input dl_t wr_dl);
      wdata_t data;
      @(negedge clk_tlx);
      tlx_wr_cmd_valid = do_wr;
      tlx_wr_cmd_opcode = 8'($urandom);
      tlx_wr_cmd_ea_or_obj = {4'($urandom), $urandom, $urandom};
      // afutag top bit tells the monitor which queue a command came from
      tlx_wr_cmd_afutag = {1'b1, 15'($urandom)};
      tlx_wr_cmd_dl = wr_dl;
      tlx_wr_cmd_pl = 3'($urandom);
      tlx_wr_cmd_actag = 12'($urandom);
      tlx_wr_cmd_pasid = 20'($urandom);
      for (int i = 0; i < `WDATA_WIDTH / 32; i++)
      begin
         data[i*32 +: 32] = $urandom;
      end
      tlx_wr_cdata_bus = data;
      tlx_rd_cmd_valid = do_rd;
      tlx_rd_cmd_opcode = 8'($urandom);
      tlx_rd_cmd_ea_or_obj = {4'($urandom), $urandom, $urandom};
      tlx_rd_cmd_afutag = {1'b0, 15'($urandom)};
      tlx_rd_cmd_dl = 2'($urandom);
      tlx_rd_cmd_pl = 3'($urandom);
      tlx_rd_cmd_actag = 12'($urandom);
      tlx_rd_cmd_pasid = 20'($urandom);
      if (do_wr)
      begin
         exp_wr_cmds.push_back(pack_word(tlx_wr_cmd_opcode, tlx_wr_cmd_ea_or_obj,
                                         tlx_wr_cmd_afutag, wr_dl, tlx_wr_cmd_pl,
                                         tlx_wr_cmd_actag, tlx_wr_cmd_pasid));
         exp_wr_data.push_back(data);
         exp_wr_dl.push_back(wr_dl);
      end
      if (do_rd)
      begin
         exp_rd_cmds.push_back(pack_word(tlx_rd_cmd_opcode, tlx_rd_cmd_ea_or_obj,
                                         tlx_rd_cmd_afutag, tlx_rd_cmd_dl, tlx_rd_cmd_pl,
                                         tlx_rd_cmd_actag, tlx_rd_cmd_pasid));
      end
   endtask

   task automatic idle_afu;
      @(negedge clk_tlx);
      tlx_wr_cmd_valid = 1'b0;
      tlx_rd_cmd_valid = 1'b0;
   endtask

   task automatic wait_drained;
      int waited;
      waited = 0;
      while ((exp_wr_cmds.size() + exp_rd_cmds.size() + exp_beats.size() != 0) &&
             (waited < DRAIN_LIMIT))
      begin
         @(negedge clk_tlx);
         waited++;
      end
      if (waited >= DRAIN_LIMIT)
      begin
         $display("%s: queued commands were not all issued within %0d cycles", cur_test,
                  DRAIN_LIMIT);
         errors++;
      end
      repeat (8) @(negedge clk_tlx);
   endtask

   task automatic begin_test(input string name);
      cur_test = name;
      test_err_start = errors;
   endtask

   task automatic end_test;
      tests_run++;
      if (errors == test_err_start)
      begin
         $display("test %s: passed", cur_test);
      end
      else
      begin
         tests_failed++;
         $display("test %s: failed with %0d errors", cur_test, errors - test_err_start);
      end
   endtask

   // ------------------------------
   // tests
   // ------------------------------
   initial
   begin
      void'($urandom(32'h6d4d));
      rst_n = 1'b0;
      tlx_wr_cmd_valid = 1'b0;
      tlx_rd_cmd_valid = 1'b0;
      send_fields_init();
      tlx_afu_cmd_credit = 1'b0;
      tlx_afu_cmd_data_credit = 1'b0;
      tlx_afu_cmd_initial_credit = 4'd0;
      tlx_afu_cmd_data_initial_credit = 6'd0;

      begin_test("write_128b");
      apply_reset(8, 20);
      repeat (12) send_cmds(1'b1, 1'b0, `DL_128B);
      idle_afu();
      wait_drained();
      end_test();

      begin_test("write_64b_and_reads");
      for (int i = 0; i < 12; i++)
      begin
         send_cmds(i % 2 == 0, 1'b1, `DL_64B);
      end
      idle_afu();
      wait_drained();
      end_test();

      // 14 writes and 10 reads queued before any credit exists
      begin_test("alternation");
      apply_reset(0, 0);
      repeat (10) send_cmds(1'b1, 1'b1, `DL_128B);
      repeat (4) send_cmds(1'b1, 1'b0, `DL_128B);
      idle_afu();
      repeat (10) @(negedge clk_tlx);
      assert (issued_log.size() == 0)
      else
      begin
         $display("mismatch in %s: issued without credits expected 0, actual %0d", cur_test,
                  issued_log.size());
         errors++;
      end
      return_credits(8, 20);
      wait_drained();
      assert (issued_log.size() == 24)
      else
      begin
         $display("mismatch in %s: issued count expected 24, actual %0d", cur_test,
                  issued_log.size());
         errors++;
      end
      // write, read pairs while both queues hold commands, then the last four writes
      for (int i = 0; i < issued_log.size(); i++)
      begin
         assert (issued_log[i] == ((i < 20) ? (i % 2 == 0) : 1'b1))
         else
         begin
            $display("mismatch in %s: source of command %0d expected %0b, actual %0b",
                     cur_test, i, (i < 20) ? (i % 2 == 0) : 1'b1, issued_log[i]);
            errors++;
         end
      end
      end_test();

      // just above the reserves, so the flags throttle every take
      begin_test("credit_respect");
      apply_reset(0, 0);
      repeat (20) send_cmds(1'b1, 1'b1, ($urandom % 2) ? `DL_128B : `DL_64B);
      idle_afu();
      // 19 writes and 20 reads wait in their queues, both above half full
      assert (tlx_wr_cmd_ready == 1'b0 && tlx_rd_cmd_ready == 1'b0)
      else
      begin
         $display("mismatch in %s: ready with both queues filled expected 00, actual %0b%0b",
                  cur_test, tlx_wr_cmd_ready, tlx_rd_cmd_ready);
         errors++;
      end
      return_credits(`CMD_CREDIT_RESERVE + 1, `DATA_CREDIT_RESERVE + 2);
      wait_drained();
      end_test();

      begin_test("ready_and_overflow");
      apply_reset(0, 0);
      for (int k = 1; k <= 36; k++)
      begin
         send_cmds(1'b1, 1'b0, `DL_128B);
         idle_afu();
         // the arbiter slot holds one write, the command queue the rest
         assert (tlx_wr_cmd_ready == (k <= 16) && tlx_rd_cmd_ready == 1'b1)
         else
         begin
            $display("mismatch in %s: ready after %0d writes expected %0b1, actual %0b%0b",
                     cur_test, k, k <= 16, tlx_wr_cmd_ready, tlx_rd_cmd_ready);
            errors++;
         end
         assert (fir_fifo_overflow == {k >= 34, 1'b0, k >= 33})
         else
         begin
            $display("mismatch in %s: overflow after %0d writes expected %b, actual %b",
                     cur_test, k, {k >= 34, 1'b0, k >= 33}, fir_fifo_overflow);
            errors++;
         end
      end
      end_test();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display(">>> PASS");
      end
      else
      begin
         $display(">>> FAIL");
      end
      $finish;
   end

   task automatic send_fields_init;
      tlx_wr_cmd_opcode = '0;
      tlx_wr_cmd_ea_or_obj = '0;
      tlx_wr_cmd_afutag = '0;
      tlx_wr_cmd_dl = '0;
      tlx_wr_cmd_pl = '0;
      tlx_wr_cmd_actag = '0;
      tlx_wr_cmd_pasid = '0;
      tlx_wr_cdata_bus = '0;
      tlx_rd_cmd_opcode = '0;
      tlx_rd_cmd_ea_or_obj = '0;
      tlx_rd_cmd_afutag = '0;
      tlx_rd_cmd_dl = '0;
      tlx_rd_cmd_pl = '0;
      tlx_rd_cmd_actag = '0;
      tlx_rd_cmd_pasid = '0;
   endtask

endmodule

`default_nettype wire

// File: tlx_cmd_converter.f
+incdir+include
logic/tlx_cmd_pkg.sv
logic/cmd_fifo.sv
logic/cmd_arbiter.sv
logic/cmd_issue.sv
logic/credit_tracker.sv
logic/tlx_cmd_converter.sv
tests/tb_tlx_cmd_converter.sv
